// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Address of the first instruction fetched after reset
`define CORE_RESET_PC 32'h0000_0000

// RV32E keeps sixteen integer registers
`define CORE_NREGS 16

// Width of a data word, a register and a PC
`define CORE_XLEN 32

`endif

// File: isa_pkg.sv
`include "core_consts.svh"

package isa_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;
	typedef logic [2:0] funct3_t; // Branch condition, or load/store width and sign

	// Instruction class as seen after decode
	typedef enum logic [3:0] {
		uop_alu,
		uop_branch,
		uop_jal,
		uop_jalr,
		uop_lui,
		uop_auipc,
		uop_load,
		uop_store,
		uop_illegal
	} uop_kind_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_none, // Retires straight away
		mem_load,
		mem_store
	} mem_kind_e;

endpackage

// File: bus_pkg.sv
`include "core_consts.svh"

package bus_pkg;

	typedef logic [`CORE_XLEN-1:0] addr_t;
	typedef logic [`CORE_XLEN/8-1:0] strb_t; // One bit per byte lane

	// Master that the outstanding request on the external port came from
	typedef enum logic {
		owner_fetch,
		owner_data
	} bus_owner_e;

endpackage

// File: core_ifs.sv
`timescale 1ns/10ps

interface mem_bus_if;
	logic req_valid;
	logic req_ready;
	logic write;
	bus_pkg::addr_t addr;
	isa_pkg::word_t wdata;
	bus_pkg::strb_t wstrb;
	logic resp_valid; // One strobe per accepted request, reads and writes alike
	isa_pkg::word_t rdata;

	modport master (output req_valid, write, addr, wdata, wstrb,
		input req_ready, resp_valid, rdata);
	modport slave (input req_valid, write, addr, wdata, wstrb,
		output req_ready, resp_valid, rdata);
endinterface

interface issue_if;
	logic valid;
	logic ready;
	isa_pkg::uop_kind_e kind;
	isa_pkg::alu_op_e alu_op;
	isa_pkg::funct3_t funct3;
	isa_pkg::reg_idx_t rd;
	isa_pkg::word_t src1;
	isa_pkg::word_t src2;
	isa_pkg::word_t imm;
	isa_pkg::word_t pc;

	modport source (output valid, kind, alu_op, funct3, rd, src1, src2, imm, pc,
		input ready);
	modport sink (input valid, kind, alu_op, funct3, rd, src1, src2, imm, pc,
		output ready);
endinterface

interface mem_op_if;
	logic valid;
	logic ready;
	isa_pkg::mem_kind_e kind;
	isa_pkg::funct3_t funct3;
	isa_pkg::reg_idx_t rd;
	logic wen;
	isa_pkg::word_t result;
	bus_pkg::addr_t addr;
	isa_pkg::word_t store_data;
	isa_pkg::word_t pc;
	isa_pkg::word_t next_pc;

	modport source (output valid, kind, funct3, rd, wen, result, addr, store_data, pc,
		next_pc, input ready);
	modport sink (input valid, kind, funct3, rd, wen, result, addr, store_data, pc,
		next_pc, output ready);
endinterface

interface retire_if;
	logic valid;
	isa_pkg::word_t pc;
	isa_pkg::word_t next_pc;
	isa_pkg::reg_idx_t rd;
	logic wen;
	isa_pkg::word_t data;

	modport source (output valid, pc, next_pc, rd, wen, data);
	modport sink (input valid, pc, next_pc, rd, wen, data);
endinterface

// File: core_ifu.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_ifu (
	input  logic clock,
	input  logic reset,
	mem_bus_if.master fetch,
	retire_if.sink retire,
	output logic inst_valid,
	input  logic inst_ready,
	output isa_pkg::word_t inst,
	output isa_pkg::word_t pc
);

	typedef enum logic [1:0] {
		request,
		wait_resp,
		offer,
		wait_retire
	} fetch_state_e;

	fetch_state_e state;
	logic boot; // Stands in for a retire strobe right after reset

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= wait_retire;
			boot <= 1'b1;
			pc <= `CORE_RESET_PC;
		end else begin
			boot <= 1'b0;
			case (state)
				request: if (fetch.req_ready) state <= wait_resp;
				wait_resp: if (fetch.resp_valid) state <= offer;
				offer: if (inst_ready) state <= wait_retire;
				default: if (retire.valid || boot) state <= request;
			endcase
			if (retire.valid)
				pc <= retire.next_pc; // Resolved by the EXU, carried through the LSU
		end
	end

	always_ff @(posedge clock) begin
		if (state == wait_resp && fetch.resp_valid)
			inst <= fetch.rdata;
	end

	assign fetch.req_valid = state == request;
	assign fetch.write = 1'b0;
	assign fetch.addr = pc;
	assign fetch.wdata = '0;
	assign fetch.wstrb = '0;
	assign inst_valid = state == offer;

	// The crossbar must never steer a data response to the fetch side
	assert property (@(posedge clock) disable iff (reset)
		fetch.resp_valid |-> state == wait_resp);

endmodule

// File: core_idu.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_idu (
	input  logic clock,
	input  logic reset,
	input  logic inst_valid,
	output logic inst_ready,
	input  isa_pkg::word_t inst,
	input  isa_pkg::word_t pc,
	issue_if.source issue,
	retire_if.sink retire
);

	isa_pkg::word_t regs [`CORE_NREGS];
	isa_pkg::reg_idx_t rs1;
	isa_pkg::reg_idx_t rs2;
	isa_pkg::word_t rdata1;
	isa_pkg::word_t rdata2;
	isa_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	isa_pkg::word_t imm;
	isa_pkg::uop_kind_e kind;
	isa_pkg::alu_op_e alu_op;
	logic use_rs1, use_rs2, use_rd;
	logic op_imm;

	function automatic isa_pkg::alu_op_e alu_decode(isa_pkg::funct3_t f3, logic f7_5,
		logic reg_op);
		case (f3)
			3'b000: return (reg_op && f7_5) ? isa_pkg::alu_sub : isa_pkg::alu_add;
			3'b001: return isa_pkg::alu_sll;
			3'b010: return isa_pkg::alu_slt;
			3'b011: return isa_pkg::alu_sltu;
			3'b100: return isa_pkg::alu_xor;
			3'b101: return f7_5 ? isa_pkg::alu_sra : isa_pkg::alu_srl;
			3'b110: return isa_pkg::alu_or;
			default: return isa_pkg::alu_and;
		endcase
	endfunction

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		kind = isa_pkg::uop_illegal;
		alu_op = isa_pkg::alu_add;
		imm = imm_i;
		use_rs1 = 1'b1;
		use_rs2 = 1'b0;
		use_rd = 1'b1;
		op_imm = 1'b0;
		case (inst[6:0])
			7'b0110111: kind = isa_pkg::uop_lui;
			7'b0010111: kind = isa_pkg::uop_auipc;
			7'b1101111: kind = isa_pkg::uop_jal;
			7'b1100111: if (inst[14:12] == 3'b000) kind = isa_pkg::uop_jalr;
			7'b1100011: if (inst[14:13] != 2'b01) kind = isa_pkg::uop_branch;
			7'b0000011: if (inst[13:12] != 2'b11 && inst[14:12] != 3'b110)
				kind = isa_pkg::uop_load;
			7'b0100011: if (inst[14:12] < 3'b011) kind = isa_pkg::uop_store;
			7'b0010011: begin
				kind = isa_pkg::uop_alu;
				alu_op = alu_decode(inst[14:12], inst[30], 1'b0);
				op_imm = 1'b1;
			end
			7'b0110011: begin
				kind = isa_pkg::uop_alu;
				alu_op = alu_decode(inst[14:12], inst[30], 1'b1);
			end
			default: ;
		endcase
		case (inst[6:0])
			7'b0110111, 7'b0010111: begin
				imm = imm_u;
				use_rs1 = 1'b0;
			end
			7'b1101111: begin
				imm = imm_j;
				use_rs1 = 1'b0;
			end
			7'b1100011: begin
				imm = imm_b;
				use_rs2 = 1'b1;
				use_rd = 1'b0;
			end
			7'b0100011: begin
				imm = imm_s;
				use_rs2 = 1'b1;
				use_rd = 1'b0;
			end
			7'b0110011: use_rs2 = 1'b1;
			default: ;
		endcase
		// RV32E has no x16 to x31
		if ((use_rs1 && inst[19]) || (use_rs2 && inst[24]) || (use_rd && inst[11]))
			kind = isa_pkg::uop_illegal;
	end

	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clock) begin
		if (retire.valid && retire.wen && retire.rd != '0)
			regs[retire.rd] <= retire.data;
	end

	assign inst_ready = !issue.valid;

	always_ff @(posedge clock) begin
		if (reset)
			issue.valid <= 1'b0;
		else if (inst_valid && inst_ready)
			issue.valid <= 1'b1;
		else if (issue.ready)
			issue.valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (inst_valid && inst_ready) begin
			issue.kind <= kind;
			issue.alu_op <= alu_op;
			issue.funct3 <= inst[14:12];
			issue.rd <= inst[10:7];
			issue.src1 <= rdata1;
			issue.src2 <= op_imm ? imm : rdata2; // The EXU always takes operand b from src2 for ALU ops
			issue.imm <= imm;
			issue.pc <= pc;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		issue.valid && issue.ready |-> issue.kind != isa_pkg::uop_illegal);

endmodule

// File: core_exu.sv
`timescale 1ns/10ps

module core_exu (
	input  logic clock,
	input  logic reset,
	issue_if.sink issue,
	mem_op_if.source mem_op
);

	isa_pkg::word_t operand_b;
	isa_pkg::word_t alu_out;
	isa_pkg::word_t pc_plus4;
	isa_pkg::word_t result;
	isa_pkg::word_t next_pc;
	isa_pkg::mem_kind_e kind;
	logic taken;
	logic wen;

	assign operand_b = (issue.kind == isa_pkg::uop_alu) ? issue.src2 : issue.imm;
	assign pc_plus4 = issue.pc + isa_pkg::word_t'(4);

	always_comb begin
		case (issue.alu_op)
			isa_pkg::alu_sub: alu_out = issue.src1 - operand_b;
			isa_pkg::alu_sll: alu_out = issue.src1 << operand_b[4:0];
			isa_pkg::alu_slt: alu_out = isa_pkg::word_t'($signed(issue.src1) < $signed(operand_b));
			isa_pkg::alu_sltu: alu_out = isa_pkg::word_t'(issue.src1 < operand_b);
			isa_pkg::alu_xor: alu_out = issue.src1 ^ operand_b;
			isa_pkg::alu_srl: alu_out = issue.src1 >> operand_b[4:0];
			isa_pkg::alu_sra: alu_out = $signed(issue.src1) >>> operand_b[4:0];
			isa_pkg::alu_or: alu_out = issue.src1 | operand_b;
			isa_pkg::alu_and: alu_out = issue.src1 & operand_b;
			default: alu_out = issue.src1 + operand_b; // Also the load/store address and jalr target
		endcase
	end

	always_comb begin
		case (issue.funct3)
			3'b000: taken = issue.src1 == issue.src2;
			3'b001: taken = issue.src1 != issue.src2;
			3'b100: taken = $signed(issue.src1) < $signed(issue.src2);
			3'b101: taken = $signed(issue.src1) >= $signed(issue.src2);
			3'b110: taken = issue.src1 < issue.src2;
			default: taken = issue.src1 >= issue.src2;
		endcase
	end

	always_comb begin
		next_pc = pc_plus4;
		result = alu_out;
		kind = isa_pkg::mem_none;
		wen = 1'b1;
		case (issue.kind)
			isa_pkg::uop_lui: result = issue.imm;
			isa_pkg::uop_auipc: result = issue.pc + issue.imm;
			isa_pkg::uop_jal: begin
				result = pc_plus4;
				next_pc = issue.pc + issue.imm;
			end
			isa_pkg::uop_jalr: begin
				result = pc_plus4;
				next_pc = {alu_out[31:1], 1'b0};
			end
			isa_pkg::uop_branch: begin
				wen = 1'b0;
				if (taken)
					next_pc = issue.pc + issue.imm;
			end
			isa_pkg::uop_load: kind = isa_pkg::mem_load;
			isa_pkg::uop_store: begin
				kind = isa_pkg::mem_store;
				wen = 1'b0;
			end
			isa_pkg::uop_illegal: wen = 1'b0; // Falls through to pc+4 as a no-op
			default: ;
		endcase
	end

	assign issue.ready = !mem_op.valid;

	always_ff @(posedge clock) begin
		if (reset)
			mem_op.valid <= 1'b0;
		else if (issue.valid && issue.ready)
			mem_op.valid <= 1'b1;
		else if (mem_op.ready)
			mem_op.valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (issue.valid && issue.ready) begin
			mem_op.kind <= kind;
			mem_op.funct3 <= issue.funct3;
			mem_op.rd <= issue.rd;
			mem_op.wen <= wen;
			mem_op.result <= result;
			mem_op.addr <= alu_out;
			mem_op.store_data <= issue.src2;
			mem_op.pc <= issue.pc;
			mem_op.next_pc <= next_pc;
		end
	end

endmodule

// File: core_lsu.sv
`timescale 1ns/10ps

module core_lsu (
	input  logic clock,
	input  logic reset,
	mem_op_if.sink mem_op,
	mem_bus_if.master data,
	retire_if.source retire
);

	typedef enum logic [1:0] {
		idle,
		request,
		wait_resp,
		done
	} lsu_state_e;

	lsu_state_e state;
	isa_pkg::mem_kind_e kind;
	isa_pkg::funct3_t funct3;
	bus_pkg::addr_t addr_q;
	isa_pkg::word_t store_q;
	isa_pkg::word_t lane;
	isa_pkg::word_t load_value;
	logic [4:0] shift;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (mem_op.valid)
					state <= (mem_op.kind == isa_pkg::mem_none) ? done : request;
				request: if (data.req_ready) state <= wait_resp;
				wait_resp: if (data.resp_valid) state <= done;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (mem_op.valid && mem_op.ready) begin
			kind <= mem_op.kind;
			funct3 <= mem_op.funct3;
			addr_q <= mem_op.addr;
			store_q <= mem_op.store_data;
			retire.pc <= mem_op.pc;
			retire.next_pc <= mem_op.next_pc;
			retire.rd <= mem_op.wen ? mem_op.rd : '0;
			retire.wen <= mem_op.wen;
			retire.data <= mem_op.result;
		end else if (state == wait_resp && data.resp_valid && kind == isa_pkg::mem_load) begin
			retire.data <= load_value;
		end
	end

	assign shift = {addr_q[1:0], 3'b000};
	assign lane = data.rdata >> shift;

	always_comb begin
		case (funct3)
			3'b000: load_value = {{24{lane[7]}}, lane[7:0]};
			3'b100: load_value = {24'b0, lane[7:0]};
			3'b001: load_value = {{16{lane[15]}}, lane[15:0]};
			3'b101: load_value = {16'b0, lane[15:0]};
			default: load_value = lane;
		endcase
	end

	always_comb begin
		case (funct3[1:0])
			2'b00: data.wstrb = bus_pkg::strb_t'(4'b0001) << addr_q[1:0];
			2'b01: data.wstrb = bus_pkg::strb_t'(4'b0011) << addr_q[1:0];
			default: data.wstrb = '1;
		endcase
	end

	assign mem_op.ready = state == idle;
	assign data.req_valid = state == request;
	assign data.write = kind == isa_pkg::mem_store;
	assign data.addr = {addr_q[31:2], 2'b00}; // Word address, lanes picked by wstrb
	assign data.wdata = store_q << shift;
	assign retire.valid = state == done;

	assert property (@(posedge clock) disable iff (reset)
		state == request |-> !(funct3[1:0] == 2'b01 && addr_q[0])
			&& !(funct3[1:0] == 2'b10 && addr_q[1:0] != 2'b00));

endmodule

// File: core_xbar.sv
`timescale 1ns/10ps

module core_xbar (
	input  logic clock,
	input  logic reset,
	mem_bus_if.slave fetch,
	mem_bus_if.slave data,
	mem_bus_if.master ext
);

	bus_pkg::bus_owner_e owner;
	logic busy;
	logic pick_data;

	assign pick_data = data.req_valid; // Data port always wins

	assign ext.req_valid = data.req_valid || fetch.req_valid;
	assign ext.write = pick_data ? data.write : fetch.write;
	assign ext.addr = pick_data ? data.addr : fetch.addr;
	assign ext.wdata = pick_data ? data.wdata : fetch.wdata;
	assign ext.wstrb = pick_data ? data.wstrb : fetch.wstrb;

	assign data.req_ready = ext.req_ready && pick_data;
	assign fetch.req_ready = ext.req_ready && !pick_data;

	assign data.resp_valid = ext.resp_valid && owner == bus_pkg::owner_data;
	assign fetch.resp_valid = ext.resp_valid && owner == bus_pkg::owner_fetch;
	assign data.rdata = ext.rdata;
	assign fetch.rdata = ext.rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			owner <= bus_pkg::owner_fetch;
		end else if (ext.req_valid && ext.req_ready) begin
			busy <= 1'b1;
			owner <= pick_data ? bus_pkg::owner_data : bus_pkg::owner_fetch;
		end else if (ext.resp_valid) begin
			busy <= 1'b0;
		end
	end

	// One instruction in flight means one bus transfer in flight
	assert property (@(posedge clock) disable iff (reset)
		ext.req_valid && ext.req_ready |-> !busy);

endmodule

// File: core_top.sv
`timescale 1ns/10ps

module core_top (
	input  logic clock,
	input  logic reset,
	output logic mem_req_valid,
	input  logic mem_req_ready,
	output logic mem_req_write,
	output bus_pkg::addr_t mem_req_addr,
	output isa_pkg::word_t mem_req_wdata,
	output bus_pkg::strb_t mem_req_wstrb,
	input  logic mem_resp_valid,
	input  isa_pkg::word_t mem_resp_rdata,
	output logic retire_valid,
	output isa_pkg::word_t retire_pc,
	output isa_pkg::reg_idx_t retire_rd,
	output isa_pkg::word_t retire_data
);

	logic inst_valid;
	logic inst_ready;
	isa_pkg::word_t inst;
	isa_pkg::word_t fetch_pc;

	mem_bus_if fetch_bus();
	mem_bus_if data_bus();
	mem_bus_if ext_bus();
	issue_if issue();
	mem_op_if mem_op();
	retire_if retire();

	core_ifu my_ifu(
		.clock(clock),
		.reset(reset),
		.fetch(fetch_bus),
		.retire(retire),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.pc(fetch_pc)
	);

	core_idu my_idu(
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst(inst),
		.pc(fetch_pc),
		.issue(issue),
		.retire(retire)
	);

	core_exu my_exu(
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.mem_op(mem_op)
	);

	core_lsu my_lsu(
		.clock(clock),
		.reset(reset),
		.mem_op(mem_op),
		.data(data_bus),
		.retire(retire)
	);

	core_xbar my_xbar(
		.clock(clock),
		.reset(reset),
		.fetch(fetch_bus),
		.data(data_bus),
		.ext(ext_bus)
	);

	assign mem_req_valid = ext_bus.req_valid;
	assign ext_bus.req_ready = mem_req_ready;
	assign mem_req_write = ext_bus.write;
	assign mem_req_addr = ext_bus.addr;
	assign mem_req_wdata = ext_bus.wdata;
	assign mem_req_wstrb = ext_bus.wstrb;
	assign ext_bus.resp_valid = mem_resp_valid;
	assign ext_bus.rdata = mem_resp_rdata;

	assign retire_valid = retire.valid;
	assign retire_pc = retire.pc;
	assign retire_rd = retire.rd; // Already zero when the instruction writes nothing
	assign retire_data = retire.data;

endmodule

// File: tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
	input  logic clock,
	input  logic reset,
	input  logic mem_req_valid,
	input  logic mem_req_ready,
	input  logic mem_req_write,
	input  logic [31:0] mem_req_addr,
	input  logic [31:0] mem_req_wdata,
	input  logic [3:0] mem_req_wstrb,
	input  logic mem_resp_valid,
	input  logic [31:0] mem_resp_rdata,
	input  logic retire_valid,
	input  logic [31:0] retire_pc,
	input  logic [3:0] retire_rd,
	input  logic [31:0] retire_data,
	output logic halt_retired
);

	string exp_name [64];
	logic [31:0] exp_addr [64];
	logic [3:0] exp_strb [64];
	logic [31:0] exp_data [64];
	int n_exp = 0;
	int n_seen = 0;
	int exp_retires = -1;
	int retires = 0;
	int passed = 0;
	int error_count = 0;
	int retire_errors = 0;
	logic halted = 1'b0;
	logic first_seen = 1'b0;
	logic reset_seen = 1'b0; // High once a clock edge has loaded the reset values
	logic held = 1'b0; // A request was offered but not accepted last cycle
	logic [68:0] held_fields;
	logic fetch_next = 1'b1; // The next accepted request fetches an instruction
	logic inst_next = 1'b0;
	logic [31:0] fetch_addr;
	logic [31:0] inst_word;

	initial begin
		halt_retired = 1'b0;
	end

	task automatic add_write(input string name, input logic [31:0] addr, input logic [3:0] strb,
		input logic [31:0] data);
		exp_name[n_exp] = name;
		exp_addr[n_exp] = addr;
		exp_strb[n_exp] = strb;
		exp_data[n_exp] = data;
		n_exp++;
	endtask

	task automatic set_retires(input int count);
		exp_retires = count;
	endtask

	task automatic check_write();
		if (n_seen >= n_exp) begin
			$display("Unexpected write to address %h with data %h", mem_req_addr, mem_req_wdata);
			error_count++;
		end else begin
			if (mem_req_addr !== exp_addr[n_seen] || mem_req_wstrb !== exp_strb[n_seen]
				|| mem_req_wdata !== exp_data[n_seen]) begin
				$display("[FAIL] %s expected %h %h %h actual %h %h %h", exp_name[n_seen],
					exp_addr[n_seen], exp_strb[n_seen], exp_data[n_seen],
					mem_req_addr, mem_req_wstrb, mem_req_wdata);
				error_count++;
			end else begin
				$display("[PASS] %s", exp_name[n_seen]);
				passed++;
			end
			n_seen++;
		end
		// The last expected write goes to the halt address
		if (n_exp > 0 && mem_req_addr === exp_addr[n_exp-1]) begin
			halted = 1'b1;
			if (n_seen != n_exp) begin
				$display("Halt reached with %0d expected writes missing", n_exp - n_seen);
				error_count++;
				n_seen = n_exp;
			end
		end
	endtask

	task automatic check_retire();
		logic [6:0] opcode;
		logic [4:0] exp_rd;
		logic [31:0] exp_value;
		logic has_value;
		opcode = inst_word[6:0];
		has_value = 1'b1;
		// Stores and branches write no register
		exp_rd = (opcode == 7'b0100011 || opcode == 7'b1100011) ? 5'd0 : inst_word[11:7];
		case (opcode)
			7'b0110111: exp_value = {inst_word[31:12], 12'h000};
			7'b0010111: exp_value = fetch_addr + {inst_word[31:12], 12'h000};
			7'b1101111, 7'b1100111: exp_value = fetch_addr + 32'd4;
			default: has_value = 1'b0;
		endcase
		if (retire_pc !== fetch_addr) begin
			$display("[FAIL] retire_pc expected %h actual %h", fetch_addr, retire_pc);
			retire_errors++;
			error_count++;
		end
		if ({1'b0, retire_rd} !== exp_rd) begin
			$display("[FAIL] retire_rd expected %0d actual %0d", exp_rd, retire_rd);
			retire_errors++;
			error_count++;
		end
		if (has_value && retire_data !== exp_value) begin
			$display("[FAIL] retire_data expected %h actual %h", exp_value, retire_data);
			retire_errors++;
			error_count++;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			if (reset_seen && (mem_req_valid !== 1'b0 || retire_valid !== 1'b0)) begin
				$display("A valid output was high during reset");
				error_count++;
			end
			reset_seen = 1'b1;
		end else begin
			if (held && (mem_req_valid !== 1'b1 || held_fields !== {mem_req_write, mem_req_addr,
				mem_req_wdata, mem_req_wstrb})) begin
				$display("A memory request changed before it was accepted");
				error_count++;
			end
			held = mem_req_valid && !mem_req_ready;
			held_fields = {mem_req_write, mem_req_addr, mem_req_wdata, mem_req_wstrb};
			if (mem_req_valid && !first_seen) begin
				first_seen = 1'b1;
				if (mem_req_write !== 1'b0 || mem_req_addr !== 32'h0) begin
					$display("[FAIL] first_fetch expected 00000000 actual %h", mem_req_addr);
					error_count++;
				end else begin
					$display("[PASS] first_fetch");
					passed++;
				end
			end
			if (mem_resp_valid === 1'b1 && inst_next) begin
				inst_word = mem_resp_rdata;
				inst_next = 1'b0;
			end
			if (mem_req_valid && mem_req_ready && fetch_next) begin
				fetch_addr = mem_req_addr;
				fetch_next = 1'b0;
				inst_next = 1'b1;
			end
			if (mem_req_valid && mem_req_ready && mem_req_write)
				check_write();
			if (retire_valid === 1'b1) begin
				retires++;
				check_retire();
				fetch_next = 1'b1;
				if (halted)
					halt_retired = 1'b1; // Only the halt store can retire after it was issued
			end
		end
	end

	task automatic final_checks(output int errors);
		if (n_seen < n_exp) begin
			$display("The run ended with %0d expected writes missing", n_exp - n_seen);
			error_count++;
		end
		if (retires != exp_retires) begin
			$display("[FAIL] retire_count expected %0d actual %0d", exp_retires, retires);
			error_count++;
		end else begin
			$display("[PASS] retire_count");
			passed++;
		end
		if (retire_errors != 0) begin
			$display("%0d retirement fields did not match the fetched instructions",
				retire_errors);
		end else if (retires > 0) begin
			$display("[PASS] retire_fields");
			passed++;
		end
		$display("Totals: %0d checks passed, %0d errors", passed, error_count);
		errors = error_count;
	endtask

endmodule

// File: tb_core.sv
`timescale 1ns/10ps

module tb_core;

	logic clock;
	logic reset;
	logic mem_req_valid;
	logic mem_req_ready;
	logic mem_req_write;
	logic [31:0] mem_req_addr;
	logic [31:0] mem_req_wdata;
	logic [3:0] mem_req_wstrb;
	logic mem_resp_valid;
	logic [31:0] mem_resp_rdata;
	logic retire_valid;
	logic [31:0] retire_pc;
	logic [3:0] retire_rd;
	logic [31:0] retire_data;
	int error_count;
	logic halt_retired;

	logic [31:0] mem [1024];
	logic [31:0] rng = 32'h48ccbd81;
	int cycles = 0;
	int limit = 0;
	int words = 0;
	logic load_ok = 1'b1;
	logic timed_out = 1'b0;
	logic acc = 1'b0;
	logic [31:0] acc_addr;
	logic [31:0] acc_wdata;
	logic [3:0] acc_wstrb;
	logic acc_write;
	logic pend = 1'b0;
	int delay = 0;
	logic [31:0] pend_rdata;

	core_top i_dut (.*);

	tb_checker i_checker (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) cycles <= cycles + 1;

	// Acceptance is seen at the rising edge and the response is driven at the falling one
	always @(posedge clock) begin
		acc <= !reset && mem_req_valid && mem_req_ready;
		acc_addr <= mem_req_addr;
		acc_wdata <= mem_req_wdata;
		acc_wstrb <= mem_req_wstrb;
		acc_write <= mem_req_write;
	end

	always @(negedge clock) begin
		mem_resp_valid = 1'b0;
		if (!reset) begin
			if (acc) begin
				rng = xorshift(rng);
				delay = 1 + rng % 3;
				pend = 1'b1;
				pend_rdata = mem[acc_addr[11:2]];
				if (acc_write)
					for (int b = 0; b < 4; b++)
						if (acc_wstrb[b])
							mem[acc_addr[11:2]][8*b +: 8] = acc_wdata[8*b +: 8];
			end
			if (pend) begin
				delay--;
				if (delay == 0) begin
					mem_resp_valid = 1'b1;
					mem_resp_rdata = pend_rdata;
					pend = 1'b0;
				end
			end
			rng = xorshift(rng);
			mem_req_ready = (rng % 3) != 0;
		end
	end

	task automatic load_patterns();
		int fd;
		int code;
		int count;
		string tag;
		string name;
		string rest;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		fd = $fopen("core_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open core_patterns.txt");
			load_ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1)
				break;
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "P") begin
				code = $fscanf(fd, "%h %h", a, d);
				mem[a[11:2]] = d;
				words++;
			end else if (tag == "W") begin
				code = $fscanf(fd, "%s %h %h %h", name, a, s, d);
				i_checker.add_write(name, a, s[3:0], d);
			end else if (tag == "C") begin
				code = $fscanf(fd, "%d", count);
				i_checker.set_retires(count);
			end else begin
				$display("Unknown line kind %s in core_patterns.txt", tag);
				load_ok = 1'b0;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		reset = 1'b1;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_rdata = '0;
		for (int i = 0; i < 1024; i++)
			mem[i] = {~i[15:0], i[15:0] ^ 16'h5a5a}; // Unloaded words are easy to spot
		load_patterns();
		limit = 60 * words + 200;
		if (load_ok) begin
			repeat (16) @(posedge clock);
			@(negedge clock);
			reset <= 1'b0;
			while (!halt_retired && cycles < limit)
				@(negedge clock);
			if (!halt_retired) begin
				$display("Timeout after %0d cycles without the halt store retiring", cycles);
				timed_out = 1'b1;
			end
		end
		i_checker.final_checks(error_count);
		if (load_ok && !timed_out && error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: core_patterns.txt
# P address word : program and data image
# W name address strb data : expected write, C count : expected retirements
P 00000000 20000113
P 00000004 123451B7
P 00000008 67818193
P 0000000C 00312023
P 00000010 FFB00213
P 00000014 404182B3
P 00000018 00512223
P 0000001C 40125313
P 00000020 0041B3B3
P 00000024 00322433
P 00000028 007344B3
P 0000002C 00441513
P 00000030 00756533
P 00000034 00001597
P 00000038 00912423
P 0000003C 00A12623
P 00000040 00B12823
P 00000044 30000613
P 00000048 00160683
P 0000004C 00D12A23
P 00000050 00364683
P 00000054 00D12C23
P 00000058 00261683
P 0000005C 00D12E23
P 00000060 00065683
P 00000064 02D12023
P 00000068 00062683
P 0000006C 02D12223
P 00000070 02310423
P 00000074 023104A3
P 00000078 02310523
P 0000007C 023105A3
P 00000080 02311623
P 00000084 02311723
P 00000088 00518663
P 0000008C 0A100713
P 00000090 02E12823
P 00000094 00324663
P 00000098 7BD00713
P 0000009C 02E12A23
P 000000A0 0B200713
P 000000A4 02E12C23
P 000000A8 00C007EF
P 000000AC 7BD00713
P 000000B0 02E12E23
P 000000B4 04F12023
P 000000B8 018780E7
P 000000BC 7BD00713
P 000000C0 02E12E23
P 000000C4 04112223
P 000000C8 0E062823
P 000000CC 0000006F
P 00000300 80F1C2A3
W lui_addi 00000200 F 12345678
W sub 00000204 F 1234567D
W srai_xor_sltu 00000208 F FFFFFFFC
W slt_slli_or 0000020C F 00000011
W auipc 00000210 F 00001034
W lb 00000214 F FFFFFFC2
W lbu 00000218 F 00000080
W lh 0000021C F FFFF80F1
W lhu 00000220 F 0000C2A3
W lw 00000224 F 80F1C2A3
W sb_0 00000228 1 12345678
W sb_1 00000228 2 34567800
W sb_2 00000228 4 56780000
W sb_3 00000228 8 78000000
W sh_0 0000022C 3 12345678
W sh_2 0000022C C 56780000
W beq_not_taken 00000230 F 000000A1
W blt_taken 00000238 F 000000B2
W jal_link 00000240 F 000000AC
W jalr_link 00000244 F 000000BC
W halt 000003F0 F 00000000
C 45

// File: tb.f
isa_pkg.sv
bus_pkg.sv
core_ifs.sv
core_ifu.sv
core_idu.sv
core_exu.sv
core_lsu.sv
core_xbar.sv
core_top.sv
tb_checker.sv
tb_core.sv
+incdir+.
